/* source/issue_defines.svh */
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// datapath widths
`define XLEN 32
`define TAG_W 4
`define OP_W 4

// station sizes
`define ALU_RS_DEPTH 4
`define DIV_RS_DEPTH 2

// functional unit codes
`define FU_W 1
`define FU_ALU 1'b0
`define FU_DIV 1'b1

`endif

/* source/issue_pkg.sv */
`include "issue_defines.svh"

package issue_pkg;

    // divider view of the op word
    typedef struct packed {
        logic                is_signed;
        logic                rem;
        logic [`OP_W-3:0]    spare;
    } div_flags_t;

    // one op word, read as alu op or as divide flags
    typedef union packed {
        logic [`OP_W-1:0]    alu;
        div_flags_t          div;
    } op_word_u;

endpackage

/* source/rs_table.sv */
`include "issue_defines.svh"

module rs_table #(
    parameter int DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,

    input  logic                enq,
    input  issue_pkg::op_word_u inst_op,
    input  logic [`TAG_W-1:0]   inst_rob_tag,
    input  logic                inst_rs1_valid,
    input  logic [`TAG_W-1:0]   inst_rs1_tag,
    input  logic [`XLEN-1:0]    inst_rs1_data,
    input  logic                inst_rs2_valid,
    input  logic [`TAG_W-1:0]   inst_rs2_tag,
    input  logic [`XLEN-1:0]    inst_rs2_data,
    input  logic [`XLEN-1:0]    inst_imm,
    input  logic                inst_use_imm,

    input  logic                cdb_valid,
    input  logic [`TAG_W-1:0]   cdb_tag,
    input  logic [`XLEN-1:0]    cdb_data,

    input  logic                grant,

    output logic                has_space,
    output logic                sel_valid,
    output issue_pkg::op_word_u sel_op,
    output logic [`TAG_W-1:0]   sel_rob_tag,
    output logic [`XLEN-1:0]    sel_src1,
    output logic [`XLEN-1:0]    sel_src2
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0]    valid_q;
    logic [DEPTH-1:0]    rs1_valid_q;
    logic [DEPTH-1:0]    rs2_valid_q;
    logic [DEPTH-1:0]    use_imm_q;
    issue_pkg::op_word_u op_q       [DEPTH];
    logic [`TAG_W-1:0]   rob_tag_q  [DEPTH];
    logic [`TAG_W-1:0]   rs1_tag_q  [DEPTH];
    logic [`TAG_W-1:0]   rs2_tag_q  [DEPTH];
    logic [`XLEN-1:0]    rs1_data_q [DEPTH];
    logic [`XLEN-1:0]    rs2_data_q [DEPTH];
    logic [`XLEN-1:0]    imm_q      [DEPTH];

    logic [DEPTH-1:0]    ready;
    logic [IDX_W-1:0]    free_idx;
    logic [IDX_W-1:0]    sel_idx;

    // imm stands in for a missing rs2
    assign ready = valid_q & rs1_valid_q & (rs2_valid_q | use_imm_q);

    // lowest free slot and lowest ready entry
    always_comb begin
        has_space = 1'b0;
        free_idx  = '0;
        sel_valid = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!valid_q[i] && !has_space) begin
                has_space = 1'b1;
                free_idx  = IDX_W'(i);
            end
            if (ready[i] && !sel_valid) begin
                sel_valid = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    assign sel_op      = op_q[sel_idx];
    assign sel_rob_tag = rob_tag_q[sel_idx];
    assign sel_src1    = rs1_data_q[sel_idx];
    assign sel_src2    = use_imm_q[sel_idx] ? imm_q[sel_idx] : rs2_data_q[sel_idx];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= '0;
        end else begin
            if (grant) begin
                valid_q[sel_idx] <= 1'b0;
            end
            if (enq) begin
                valid_q[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // wakeup only touches resident entries
        for (int i = 0; i < DEPTH; i++) begin
            if (cdb_valid && valid_q[i]) begin
                if (!rs1_valid_q[i] && rs1_tag_q[i] == cdb_tag) begin
                    rs1_valid_q[i] <= 1'b1;
                    rs1_data_q[i]  <= cdb_data;
                end
                if (!rs2_valid_q[i] && rs2_tag_q[i] == cdb_tag) begin
                    rs2_valid_q[i] <= 1'b1;
                    rs2_data_q[i]  <= cdb_data;
                end
            end
        end
        if (enq) begin
            op_q[free_idx]        <= inst_op;
            rob_tag_q[free_idx]   <= inst_rob_tag;
            rs1_valid_q[free_idx] <= inst_rs1_valid;
            rs1_tag_q[free_idx]   <= inst_rs1_tag;
            rs1_data_q[free_idx]  <= inst_rs1_data;
            rs2_valid_q[free_idx] <= inst_rs2_valid;
            rs2_tag_q[free_idx]   <= inst_rs2_tag;
            rs2_data_q[free_idx]  <= inst_rs2_data;
            imm_q[free_idx]       <= inst_imm;
            use_imm_q[free_idx]   <= inst_use_imm;
        end
    end

endmodule

/* source/dispatch_router.sv */
`include "issue_defines.svh"

module dispatch_router (
    input  logic             inst_valid,
    input  logic [`FU_W-1:0] inst_fu,
    input  logic             alu_has_space,
    input  logic             div_has_space,
    output logic             inst_ready,
    output logic             alu_enq,
    output logic             div_enq
);

    logic want_alu;
    logic want_div;

    assign want_alu = (inst_fu == `FU_ALU);
    assign want_div = (inst_fu == `FU_DIV);

    // stall only on the target station
    assign inst_ready = (want_alu && alu_has_space) || (want_div && div_has_space);

    assign alu_enq = inst_valid && inst_ready && want_alu;
    assign div_enq = inst_valid && inst_ready && want_div;

endmodule

/* source/alu_issue_port.sv */
`include "issue_defines.svh"

module alu_issue_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,

    input  logic                sel_valid,
    input  issue_pkg::op_word_u sel_op,
    input  logic [`TAG_W-1:0]   sel_rob_tag,
    input  logic [`XLEN-1:0]    sel_src1,
    input  logic [`XLEN-1:0]    sel_src2,

    output logic                grant,
    output logic                alu_valid,
    output logic [`OP_W-1:0]    alu_op,
    output logic [`TAG_W-1:0]   alu_rob_tag,
    output logic [`XLEN-1:0]    alu_src1,
    output logic [`XLEN-1:0]    alu_src2
);

    // no back-pressure from the alu
    assign grant = sel_valid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            alu_op      <= sel_op.alu;
            alu_rob_tag <= sel_rob_tag;
            alu_src1    <= sel_src1;
            alu_src2    <= sel_src2;
        end
    end

endmodule

/* source/div_issue_port.sv */
`include "issue_defines.svh"

module div_issue_port (
    input  logic                div_busy,

    input  logic                sel_valid,
    input  issue_pkg::op_word_u sel_op,
    input  logic [`TAG_W-1:0]   sel_rob_tag,
    input  logic [`XLEN-1:0]    sel_src1,
    input  logic [`XLEN-1:0]    sel_src2,

    output logic                grant,
    output logic                div_start,
    output logic                div_signed,
    output logic                div_rem,
    output logic [`TAG_W-1:0]   div_rob_tag,
    output logic [`XLEN-1:0]    div_src1,
    output logic [`XLEN-1:0]    div_src2
);

    // entry waits in the station while the divider is busy
    assign grant     = sel_valid && !div_busy;
    assign div_start = grant;

    assign div_signed  = sel_op.div.is_signed;
    assign div_rem     = sel_op.div.rem;
    assign div_rob_tag = sel_rob_tag;
    assign div_src1    = sel_src1;
    assign div_src2    = sel_src2;

endmodule

/* source/issue_top.sv */
`include "issue_defines.svh"

module issue_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                div_busy,

    input  logic                inst_valid,
    input  logic [`FU_W-1:0]    inst_fu,
    input  issue_pkg::op_word_u inst_op,
    input  logic [`TAG_W-1:0]   inst_rob_tag,
    input  logic                inst_rs1_valid,
    input  logic [`TAG_W-1:0]   inst_rs1_tag,
    input  logic [`XLEN-1:0]    inst_rs1_data,
    input  logic                inst_rs2_valid,
    input  logic [`TAG_W-1:0]   inst_rs2_tag,
    input  logic [`XLEN-1:0]    inst_rs2_data,
    input  logic [`XLEN-1:0]    inst_imm,
    input  logic                inst_use_imm,
    output logic                inst_ready,

    input  logic                cdb_valid,
    input  logic [`TAG_W-1:0]   cdb_tag,
    input  logic [`XLEN-1:0]    cdb_data,

    output logic                alu_valid,
    output logic [`OP_W-1:0]    alu_op,
    output logic [`TAG_W-1:0]   alu_rob_tag,
    output logic [`XLEN-1:0]    alu_src1,
    output logic [`XLEN-1:0]    alu_src2,

    output logic                div_start,
    output logic                div_signed,
    output logic                div_rem,
    output logic [`TAG_W-1:0]   div_rob_tag,
    output logic [`XLEN-1:0]    div_src1,
    output logic [`XLEN-1:0]    div_src2
);

    logic                alu_enq;
    logic                alu_has_space;
    logic                alu_grant;
    logic                alu_sel_valid;
    issue_pkg::op_word_u alu_sel_op;
    logic [`TAG_W-1:0]   alu_sel_rob_tag;
    logic [`XLEN-1:0]    alu_sel_src1;
    logic [`XLEN-1:0]    alu_sel_src2;

    logic                div_enq;
    logic                div_has_space;
    logic                div_grant;
    logic                div_sel_valid;
    issue_pkg::op_word_u div_sel_op;
    logic [`TAG_W-1:0]   div_sel_rob_tag;
    logic [`XLEN-1:0]    div_sel_src1;
    logic [`XLEN-1:0]    div_sel_src2;

    dispatch_router i_router (
        .inst_valid    (inst_valid),
        .inst_fu       (inst_fu),
        .alu_has_space (alu_has_space),
        .div_has_space (div_has_space),
        .inst_ready    (inst_ready),
        .alu_enq       (alu_enq),
        .div_enq       (div_enq)
    );

    rs_table #(.DEPTH(`ALU_RS_DEPTH)) i_alu_rs (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .enq            (alu_enq),
        .inst_op        (inst_op),
        .inst_rob_tag   (inst_rob_tag),
        .inst_rs1_valid (inst_rs1_valid),
        .inst_rs1_tag   (inst_rs1_tag),
        .inst_rs1_data  (inst_rs1_data),
        .inst_rs2_valid (inst_rs2_valid),
        .inst_rs2_tag   (inst_rs2_tag),
        .inst_rs2_data  (inst_rs2_data),
        .inst_imm       (inst_imm),
        .inst_use_imm   (inst_use_imm),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .grant          (alu_grant),
        .has_space      (alu_has_space),
        .sel_valid      (alu_sel_valid),
        .sel_op         (alu_sel_op),
        .sel_rob_tag    (alu_sel_rob_tag),
        .sel_src1       (alu_sel_src1),
        .sel_src2       (alu_sel_src2)
    );

    rs_table #(.DEPTH(`DIV_RS_DEPTH)) i_div_rs (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .enq            (div_enq),
        .inst_op        (inst_op),
        .inst_rob_tag   (inst_rob_tag),
        .inst_rs1_valid (inst_rs1_valid),
        .inst_rs1_tag   (inst_rs1_tag),
        .inst_rs1_data  (inst_rs1_data),
        .inst_rs2_valid (inst_rs2_valid),
        .inst_rs2_tag   (inst_rs2_tag),
        .inst_rs2_data  (inst_rs2_data),
        .inst_imm       (inst_imm),
        .inst_use_imm   (inst_use_imm),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .grant          (div_grant),
        .has_space      (div_has_space),
        .sel_valid      (div_sel_valid),
        .sel_op         (div_sel_op),
        .sel_rob_tag    (div_sel_rob_tag),
        .sel_src1       (div_sel_src1),
        .sel_src2       (div_sel_src2)
    );

    alu_issue_port i_alu_port (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .sel_valid   (alu_sel_valid),
        .sel_op      (alu_sel_op),
        .sel_rob_tag (alu_sel_rob_tag),
        .sel_src1    (alu_sel_src1),
        .sel_src2    (alu_sel_src2),
        .grant       (alu_grant),
        .alu_valid   (alu_valid),
        .alu_op      (alu_op),
        .alu_rob_tag (alu_rob_tag),
        .alu_src1    (alu_src1),
        .alu_src2    (alu_src2)
    );

    div_issue_port i_div_port (
        .div_busy    (div_busy),
        .sel_valid   (div_sel_valid),
        .sel_op      (div_sel_op),
        .sel_rob_tag (div_sel_rob_tag),
        .sel_src1    (div_sel_src1),
        .sel_src2    (div_sel_src2),
        .grant       (div_grant),
        .div_start   (div_start),
        .div_signed  (div_signed),
        .div_rem     (div_rem),
        .div_rob_tag (div_rob_tag),
        .div_src1    (div_src1),
        .div_src2    (div_src2)
    );

endmodule

/* dv/issue_properties.sv */
`include "issue_defines.svh"

module issue_properties (
    input logic                clk,
    input logic                rst,
    input logic                flush,
    input logic                div_busy,
    input logic                inst_valid,
    input logic [`FU_W-1:0]    inst_fu,
    input issue_pkg::op_word_u inst_op,
    input logic [`TAG_W-1:0]   inst_rob_tag,
    input logic                inst_rs1_valid,
    input logic [`TAG_W-1:0]   inst_rs1_tag,
    input logic                inst_rs2_valid,
    input logic [`TAG_W-1:0]   inst_rs2_tag,
    input logic                inst_use_imm,
    input logic                inst_ready,
    input logic                cdb_valid,
    input logic [`TAG_W-1:0]   cdb_tag,
    input logic                alu_valid,
    input logic [`OP_W-1:0]    alu_op,
    input logic [`TAG_W-1:0]   alu_rob_tag,
    input logic [`XLEN-1:0]    alu_src1,
    input logic [`XLEN-1:0]    alu_src2,
    input logic                div_start,
    input logic                div_signed,
    input logic                div_rem,
    input logic [`TAG_W-1:0]   div_rob_tag,
    input logic [`XLEN-1:0]    div_src1,
    input logic [`XLEN-1:0]    div_src2,
    input logic                alu_grant,
    input logic [`TAG_W-1:0]   alu_sel_rob_tag,
    input logic                alu_has_space,
    input logic                div_has_space
);

    localparam int NTAGS = 1 << `TAG_W;

    int unsigned fail_count = 0;

    logic [`OP_W-1:0]  op_tab [NTAGS];
    logic              pend1  [NTAGS];
    logic              pend2  [NTAGS];
    logic [`TAG_W-1:0] prod1  [NTAGS];
    logic [`TAG_W-1:0] prod2  [NTAGS];
    logic              div_res [NTAGS];
    int                alu_occ;
    int                div_occ;
    logic              flushed;
    logic              acc;
    logic              alu_acc;
    logic              div_waiting;

    // operand signature: tag across the word, plus 1 for source 2
    function automatic logic [`XLEN-1:0] src1_sig(input logic [`TAG_W-1:0] tag);
        return {(`XLEN / `TAG_W){tag}};
    endfunction

    function automatic logic [`XLEN-1:0] src2_sig(input logic [`TAG_W-1:0] tag);
        return src1_sig(tag) + `XLEN'(1);
    endfunction

    assign acc     = inst_valid && inst_ready;
    assign alu_acc = acc && (inst_fu == `FU_ALU);

    // some resident divide entry has all its operands
    always_comb begin
        div_waiting = 1'b0;
        for (int t = 0; t < NTAGS; t++) begin
            if (div_res[t] && !pend1[t] && !pend2[t]) div_waiting = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            alu_occ <= 0;
            div_occ <= 0;
        end else begin
            alu_occ <= alu_occ + int'(alu_acc) - int'(alu_grant);
            div_occ <= div_occ + int'(acc && inst_fu == `FU_DIV) - int'(div_start);
        end
        if (rst) begin
            flushed <= 1'b0;
        end else if (flush) begin
            flushed <= 1'b1;
        end else if (acc) begin
            flushed <= 1'b0;
        end
        // divide entries held in the station, by rob tag
        for (int t = 0; t < NTAGS; t++) begin
            if (rst || flush) div_res[t] <= 1'b0;
        end
        if (!rst && !flush) begin
            if (div_start) div_res[div_rob_tag] <= 1'b0;
            if (acc && inst_fu == `FU_DIV) div_res[inst_rob_tag] <= 1'b1;
        end
        // producer bookkeeping per consumer tag
        for (int t = 0; t < NTAGS; t++) begin
            if (rst) begin
                pend1[t] <= 1'b0;
                pend2[t] <= 1'b0;
            end else if (cdb_valid) begin
                if (prod1[t] == cdb_tag) pend1[t] <= 1'b0;
                if (prod2[t] == cdb_tag) pend2[t] <= 1'b0;
            end
        end
        if (!rst && acc) begin
            op_tab[inst_rob_tag] <= inst_op.alu;
            pend1[inst_rob_tag]  <= !inst_rs1_valid;
            prod1[inst_rob_tag]  <= inst_rs1_tag;
            pend2[inst_rob_tag]  <= !inst_rs2_valid && !inst_use_imm;
            prod2[inst_rob_tag]  <= inst_rs2_tag;
        end
    end

    a_reset: assert property (@(posedge clk) $fell(rst) |-> !alu_valid && !div_start && inst_ready)
        else begin
            fail_count++;
            $error("outputs not idle after reset");
        end

    a_direct: assert property (@(posedge clk) disable iff (rst || flush)
        alu_acc && inst_rs1_valid && (inst_rs2_valid || inst_use_imm) && alu_occ == 0
        |-> ##2 alu_valid && alu_rob_tag == $past(inst_rob_tag, 2))
        else begin
            fail_count++;
            $error("ready ALU instruction did not issue exactly two cycles after accept");
        end

    a_alu_src1: assert property (@(posedge clk) disable iff (rst)
        alu_valid |-> alu_src1 == src1_sig(alu_rob_tag))
        else begin
            fail_count++;
            $error("Fail at %0t: alu_src1 is %h, expected %h", $time, alu_src1,
                src1_sig(alu_rob_tag));
        end

    a_alu_src2: assert property (@(posedge clk) disable iff (rst)
        alu_valid |-> alu_src2 == src2_sig(alu_rob_tag))
        else begin
            fail_count++;
            $error("Fail at %0t: alu_src2 is %h, expected %h", $time, alu_src2,
                src2_sig(alu_rob_tag));
        end

    a_alu_op: assert property (@(posedge clk) disable iff (rst)
        alu_valid |-> alu_op == op_tab[alu_rob_tag])
        else begin
            fail_count++;
            $error("Fail at %0t: alu_op is %h, expected %h", $time, alu_op,
                op_tab[alu_rob_tag]);
        end

    // nothing issues before all its producers were broadcast
    a_alu_wait: assert property (@(posedge clk) disable iff (rst)
        alu_grant |-> !pend1[alu_sel_rob_tag] && !pend2[alu_sel_rob_tag])
        else begin
            fail_count++;
            $error("ALU entry issued while still waiting on an operand");
        end

    a_div_wait: assert property (@(posedge clk) disable iff (rst)
        div_start |-> !pend1[div_rob_tag] && !pend2[div_rob_tag])
        else begin
            fail_count++;
            $error("divide entry issued while still waiting on an operand");
        end

    a_div_src1: assert property (@(posedge clk) disable iff (rst)
        div_start |-> div_src1 == src1_sig(div_rob_tag))
        else begin
            fail_count++;
            $error("Fail at %0t: div_src1 is %h, expected %h", $time, div_src1,
                src1_sig(div_rob_tag));
        end

    a_div_src2: assert property (@(posedge clk) disable iff (rst)
        div_start |-> div_src2 == src2_sig(div_rob_tag))
        else begin
            fail_count++;
            $error("Fail at %0t: div_src2 is %h, expected %h", $time, div_src2,
                src2_sig(div_rob_tag));
        end

    // signed flag is the top bit of the op word, remainder the next one
    a_div_flags: assert property (@(posedge clk) disable iff (rst)
        div_start |-> div_signed == op_tab[div_rob_tag][`OP_W-1]
            && div_rem == op_tab[div_rob_tag][`OP_W-2])
        else begin
            fail_count++;
            $error("Fail at %0t: div_signed,div_rem are %b%b, expected %b", $time,
                div_signed, div_rem, op_tab[div_rob_tag][`OP_W-1 -: 2]);
        end

    a_alu_stall: assert property (@(posedge clk) disable iff (rst)
        inst_fu == `FU_ALU |-> inst_ready == (alu_occ < `ALU_RS_DEPTH))
        else begin
            fail_count++;
            $error("Fail at %0t: inst_ready is %b for ALU, expected %b", $time, inst_ready,
                alu_occ < `ALU_RS_DEPTH);
        end

    a_div_stall: assert property (@(posedge clk) disable iff (rst)
        inst_fu == `FU_DIV |-> inst_ready == (div_occ < `DIV_RS_DEPTH))
        else begin
            fail_count++;
            $error("Fail at %0t: inst_ready is %b for divide, expected %b", $time,
                inst_ready, div_occ < `DIV_RS_DEPTH);
        end

    a_div_busy: assert property (@(posedge clk) disable iff (rst) div_start |-> !div_busy)
        else begin
            fail_count++;
            $error("div_start raised while the divider was busy");
        end

    a_div_idle: assert property (@(posedge clk) disable iff (rst || flush)
        !div_busy && div_waiting |-> div_start)
        else begin
            fail_count++;
            $error("ready divide entry did not start while the divider was idle");
        end

    a_flush: assert property (@(posedge clk) disable iff (rst)
        flushed |-> !alu_valid && !div_start && alu_has_space && div_has_space)
        else begin
            fail_count++;
            $error("issue or stall seen after flush before any new dispatch");
        end

endmodule

bind issue_top issue_properties i_props (.*);

/* dv/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // two cycles of reset
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* dv/tb_issue.sv */
`include "issue_defines.svh"

module tb_issue;

    localparam int MAX_CYCLES = 400;
    localparam int NTAGS      = 1 << `TAG_W;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                div_busy;
    logic                inst_valid;
    logic [`FU_W-1:0]    inst_fu;
    issue_pkg::op_word_u inst_op;
    logic [`TAG_W-1:0]   inst_rob_tag;
    logic                inst_rs1_valid;
    logic [`TAG_W-1:0]   inst_rs1_tag;
    logic [`XLEN-1:0]    inst_rs1_data;
    logic                inst_rs2_valid;
    logic [`TAG_W-1:0]   inst_rs2_tag;
    logic [`XLEN-1:0]    inst_rs2_data;
    logic [`XLEN-1:0]    inst_imm;
    logic                inst_use_imm;
    logic                inst_ready;
    logic                cdb_valid;
    logic [`TAG_W-1:0]   cdb_tag;
    logic [`XLEN-1:0]    cdb_data;
    logic                alu_valid;
    logic [`OP_W-1:0]    alu_op;
    logic [`TAG_W-1:0]   alu_rob_tag;
    logic [`XLEN-1:0]    alu_src1;
    logic [`XLEN-1:0]    alu_src2;
    logic                div_start;
    logic                div_signed;
    logic                div_rem;
    logic [`TAG_W-1:0]   div_rob_tag;
    logic [`XLEN-1:0]    div_src1;
    logic [`XLEN-1:0]    div_src2;

    int errors = 0;
    int cycles = 0;
    bit alu_seen [NTAGS];
    bit div_seen [NTAGS];

    tb_clock i_clock (
        .clk (clk),
        .rst (rst)
    );

    issue_top i_dut (.*);

    function automatic logic [`XLEN-1:0] src1_sig(input int tag);
        logic [`TAG_W-1:0] t;
        t = tag[`TAG_W-1:0];
        return {(`XLEN / `TAG_W){t}};
    endfunction

    function automatic logic [`XLEN-1:0] src2_sig(input int tag);
        return src1_sig(tag) + `XLEN'(1);
    endfunction

    // issued tags, sampled mid-cycle
    always @(negedge clk) begin
        if (alu_valid) alu_seen[alu_rob_tag] = 1'b1;
        if (div_start) div_seen[div_rob_tag] = 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // present one instruction for a single cycle
    task automatic offer(input logic [`FU_W-1:0] fu, input int tag, input logic r1v,
            input int p1, input logic r2v, input int p2, input logic imm, output bit taken);
        inst_valid     = 1'b1;
        inst_fu        = fu;
        inst_op        = `OP_W'($urandom);
        inst_rob_tag   = `TAG_W'(tag);
        inst_rs1_valid = r1v;
        inst_rs1_tag   = `TAG_W'(p1);
        inst_rs1_data  = src1_sig(tag);
        inst_rs2_valid = r2v;
        inst_rs2_tag   = `TAG_W'(p2);
        inst_rs2_data  = src2_sig(tag);
        inst_imm       = src2_sig(tag);
        inst_use_imm   = imm;
        alu_seen[tag]  = 1'b0;
        div_seen[tag]  = 1'b0;
        #1 taken = inst_ready;
        @(posedge clk);
        #1 inst_valid = 1'b0;
    endtask

    task automatic dispatch(input logic [`FU_W-1:0] fu, input int tag, input logic r1v,
            input int p1, input logic r2v, input int p2, input logic imm);
        bit taken;
        for (int i = 0; i < 20; i++) begin
            offer(fu, tag, r1v, p1, r2v, p2, imm, taken);
            if (taken) return;
        end
        errors++;
        $display("instruction with rob tag %0d was never accepted", tag);
    endtask

    task automatic broadcast(input int tag, input logic [`XLEN-1:0] data);
        cdb_valid = 1'b1;
        cdb_tag   = `TAG_W'(tag);
        cdb_data  = data;
        step(1);
        cdb_valid = 1'b0;
    endtask

    task automatic expect_issue(input bit is_div, input int tag);
        int n;
        n = 0;
        while (!(is_div ? div_seen[tag] : alu_seen[tag]) && n < 20) begin
            step(1);
            n++;
        end
        if (!(is_div ? div_seen[tag] : alu_seen[tag])) begin
            errors++;
            $display("rob tag %0d was never issued", tag);
        end
    endtask

    task automatic expect_quiet(input int tag);
        if (alu_seen[tag] || div_seen[tag]) begin
            errors++;
            $display("rob tag %0d issued although it was flushed", tag);
        end
    endtask

    initial begin
        bit taken;
        void'($urandom(69));
        flush          = 1'b0;
        div_busy       = 1'b0;
        inst_valid     = 1'b0;
        inst_fu        = `FU_ALU;
        inst_op        = '0;
        inst_rob_tag   = '0;
        inst_rs1_valid = 1'b0;
        inst_rs1_tag   = '0;
        inst_rs1_data  = '0;
        inst_rs2_valid = 1'b0;
        inst_rs2_tag   = '0;
        inst_rs2_data  = '0;
        inst_imm       = '0;
        inst_use_imm   = 1'b0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_data       = '0;
        wait (!rst);
        step(2);

        // direct issue, register and immediate source 2
        dispatch(`FU_ALU, 1, 1'b1, 0, 1'b1, 0, 1'b0);
        expect_issue(1'b0, 1);
        dispatch(`FU_ALU, 2, 1'b1, 0, 1'b0, 0, 1'b1);
        expect_issue(1'b0, 2);

        // wakeup on two producers, then a divide on one
        dispatch(`FU_ALU, 3, 1'b0, 9, 1'b0, 10, 1'b0);
        step(3);
        broadcast(9, src1_sig(3));
        step(2);
        broadcast(10, src2_sig(3));
        expect_issue(1'b0, 3);
        dispatch(`FU_DIV, 4, 1'b0, 11, 1'b1, 0, 1'b1);
        step(2);
        broadcast(11, src1_sig(4));
        expect_issue(1'b1, 4);

        // fill the ALU station with waiting entries
        for (int t = 5; t <= 8; t++) begin
            dispatch(`FU_ALU, t, 1'b0, t + 7, 1'b0, 0, 1'b1);
        end
        offer(`FU_ALU, 0, 1'b1, 0, 1'b1, 0, 1'b0, taken);
        if (taken) begin
            errors++;
            $display("ALU instruction accepted into a full station");
        end

        // divide still accepted, held while the divider is busy
        div_busy = 1'b1;
        dispatch(`FU_DIV, 9, 1'b1, 0, 1'b1, 0, 1'b0);
        step(3);
        div_busy = 1'b0;
        expect_issue(1'b1, 9);

        for (int t = 5; t <= 8; t++) begin
            broadcast(t + 7, src1_sig(t));
        end
        for (int t = 5; t <= 8; t++) begin
            expect_issue(1'b0, t);
        end

        // flush drops waiting entries and the pending ALU packet
        dispatch(`FU_ALU, 10, 1'b0, 1, 1'b0, 0, 1'b1);
        dispatch(`FU_DIV, 11, 1'b0, 2, 1'b0, 0, 1'b1);
        dispatch(`FU_ALU, 12, 1'b1, 0, 1'b1, 0, 1'b0);
        flush = 1'b1;
        step(1);
        flush = 1'b0;
        broadcast(1, src1_sig(10));
        broadcast(2, src1_sig(11));
        step(4);
        expect_quiet(10);
        expect_quiet(11);
        expect_quiet(12);

        dispatch(`FU_ALU, 13, 1'b1, 0, 1'b1, 0, 1'b0);
        expect_issue(1'b0, 13);
        dispatch(`FU_DIV, 14, 1'b1, 0, 1'b0, 0, 1'b1);
        expect_issue(1'b1, 14);
        step(3);

        $display("errors: %0d testbench, %0d assertion", errors, i_dut.i_props.fail_count);
        if (errors == 0 && i_dut.i_props.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+source
source/issue_pkg.sv
source/rs_table.sv
source/dispatch_router.sv
source/alu_issue_port.sv
source/div_issue_port.sv
source/issue_top.sv
dv/issue_properties.sv
dv/tb_clock.sv
dv/tb_issue.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_issue
FILELIST  ?= files.f
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
